// ==== Makefile ====
# rename core simulation with Verilator

.PHONY: help test clean

help:
	@echo "make help   list the targets"
	@echo "make test   build and run the rename core testbench"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f build.f --top-module tb_rename
	@out="$$(./obj_dir/Vtb_rename)"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+tb
design/rename_pkg.sv
design/recover_if.sv
design/reorder_buffer.sv
design/free_list.sv
design/map_table.sv
design/rename_top.sv
tb/tb_rename.sv

// ==== design/free_list.sv ====
//**********************************************************
// circular queue of free physical tags
// one head checkpoint for branch recovery
//**********************************************************

`default_nettype none
`timescale 1ns/100ps

module free_list
  import rename_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   alloc,
  input  logic   release_valid,
  input  preg_t  release_tag,
  recover_if.blk recover,
  output preg_t  head_tag
);

  localparam int ptr_w = $clog2(free_count);
  localparam int cnt_w = ptr_w + 1;

  preg_t            fifo [free_count];
  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [ptr_w-1:0] head_ckpt;
  logic [ptr_w-1:0] head_next;
  logic [ptr_w-1:0] rollback;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] count_next;
  logic             push;

  // tag zero marks a retire with no destination
  assign push = release_valid && (release_tag != '0);

  always_comb begin
    // tags handed out since the checkpoint
    rollback = head - head_ckpt;
    if (recover.mispredict) begin
      head_next  = head_ckpt;
      count_next = count + cnt_w'(rollback) + cnt_w'(push);
    end else begin
      head_next  = head + ptr_w'(alloc);
      count_next = count + cnt_w'(push) - cnt_w'(alloc);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= cnt_w'(free_count);
      // tags above the identity map, in order
      for (int i = 0; i < free_count; i++) begin
        fifo[i] <= preg_t'(areg_count + i);
      end
    end else begin
      head  <= head_next;
      count <= count_next;
      if (push) begin
        fifo[tail] <= release_tag;
        tail <= tail + 1'b1;
      end
    end
  end

  // saved head includes the branch's own allocation
  always_ff @(posedge clock) begin
    if (recover.take_checkpoint) begin
      head_ckpt <= head_next;
    end
  end

  assign head_tag = fifo[head];

  a_no_underflow : assert property (
    @(posedge clock) disable iff (reset)
    alloc |-> (count != '0)
  );

endmodule

`default_nettype wire

// ==== design/map_table.sv ====
//**********************************************************
// architectural to physical map table
// one-deep snapshot for branch recovery
//**********************************************************

`default_nettype none
`timescale 1ns/100ps

module map_table
  import rename_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   rename,
  input  areg_t  dest_areg,
  input  preg_t  t_new,
  recover_if.blk recover,
  output preg_t  t_old
);

  preg_t map_q    [areg_count];
  preg_t map_next [areg_count];
  preg_t snap_q   [areg_count];
  logic  ckpt_valid;

  // current mapping before this cycle's rename
  assign t_old = map_q[dest_areg];

  always_comb begin
    map_next = map_q;
    if (rename) begin
      map_next[dest_areg] = t_new;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, areg i in preg i
      for (int i = 0; i < areg_count; i++) begin
        map_q[i] <= preg_t'(i);
      end
    end else if (recover.mispredict) begin
      map_q <= snap_q;
    end else begin
      map_q <= map_next;
    end
  end

  // snapshot holds the map as it stands after the branch
  always_ff @(posedge clock) begin
    if (recover.take_checkpoint) begin
      snap_q <= map_next;
    end
  end

  // tracks whether a branch is still unresolved
  always_ff @(posedge clock) begin
    if (reset) begin
      ckpt_valid <= 1'b0;
    end else if (recover.take_checkpoint) begin
      ckpt_valid <= 1'b1;
    end else if (recover.resolve || recover.mispredict) begin
      ckpt_valid <= 1'b0;
    end
  end

  // recovery needs a snapshot to restore
  a_mispredict_has_ckpt : assert property (
    @(posedge clock) disable iff (reset)
    recover.mispredict |-> ckpt_valid
  );

  // only one branch outstanding at a time
  a_single_branch : assert property (
    @(posedge clock) disable iff (reset)
    recover.take_checkpoint |-> (!ckpt_valid || recover.resolve)
  );

endmodule

`default_nettype wire

// ==== design/recover_if.sv ====
//**********************************************************
// branch checkpoint and mispredict controls
//**********************************************************

`default_nettype none
`timescale 1ns/100ps

interface recover_if #(
  parameter int rob_depth = 8
) ();

  localparam int idx_w = $clog2(rob_depth);

  // accepted dispatch is a branch, save map and free list head
  logic             take_checkpoint;
  // branch at branch_idx went the wrong way
  logic             mispredict;
  logic [idx_w-1:0] branch_idx;
  // branch was correct, checkpoint no longer needed
  logic             resolve;

  modport blk (
    input take_checkpoint,
    input mispredict,
    input branch_idx,
    input resolve
  );

endinterface

`default_nettype wire

// ==== design/rename_pkg.sv ====
//**********************************************************
// rename types and fixed sizes shared by the rename core
// physical tags, architectural numbers, ROB entry layout
//**********************************************************

`default_nettype none

package rename_pkg;

  // physical and architectural register file sizes
  localparam int preg_count = 64;
  localparam int areg_count = 32;

  // tags not mapped after reset start out in the free list
  localparam int free_count = preg_count - areg_count;

  localparam int preg_w = $clog2(preg_count);
  localparam int areg_w = $clog2(areg_count);

  // physical tag, 6 bits
  typedef logic [preg_w-1:0] preg_t;

  // architectural register number, 5 bits
  typedef logic [areg_w-1:0] areg_t;

  // one ROB slot
  // t_old is zero when the instruction had no destination
  typedef struct packed {
    logic  valid;
    preg_t t;
    preg_t t_old;
  } rob_entry_t;

endpackage

`default_nettype wire

// ==== design/rename_top.sv ====
//**********************************************************
// rename core top level
// ROB, free list and map table with branch recovery
//**********************************************************

`default_nettype none
`timescale 1ns/100ps

module rename_top
  import rename_pkg::*;
#(
  parameter int  rob_depth = 8,
  localparam int idx_w     = $clog2(rob_depth)
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             dispatch,
  input  logic             dest_valid,
  input  areg_t            dest_areg,
  input  logic             is_branch,
  input  logic             retire,
  input  logic             mispredict,
  input  logic [idx_w-1:0] branch_idx,
  input  logic             resolve,
  output logic             stall,
  output preg_t            dispatch_t,
  output preg_t            dispatch_t_old,
  output logic [idx_w-1:0] dispatch_rob_idx,
  output logic [idx_w-1:0] head_idx,
  output logic             retire_valid,
  output preg_t            retire_t,
  output preg_t            retire_t_old
);

  preg_t head_tag;
  preg_t map_t_old;
  logic  dispatch_accept;
  logic  rename;

  recover_if #(.rob_depth(rob_depth)) recover ();

  assign recover.take_checkpoint = dispatch_accept & is_branch;
  assign recover.mispredict      = mispredict;
  assign recover.branch_idx      = branch_idx;
  assign recover.resolve         = resolve;

  // only a destination takes a new tag
  assign rename = dispatch_accept & dest_valid;

  assign dispatch_t     = dest_valid ? head_tag : '0;
  assign dispatch_t_old = dest_valid ? map_t_old : '0;

  reorder_buffer #(.rob_depth(rob_depth)) u_rob (
    .clock           (clock),
    .reset           (reset),
    .dispatch        (dispatch),
    .dest_valid      (dest_valid),
    .t_new           (head_tag),
    .t_old_in        (map_t_old),
    .retire          (retire),
    .recover         (recover.blk),
    .dispatch_accept (dispatch_accept),
    .stall           (stall),
    .rob_idx         (dispatch_rob_idx),
    .head_idx        (head_idx),
    .retire_valid    (retire_valid),
    .retire_t        (retire_t),
    .retire_t_old    (retire_t_old)
  );

  // retired t_old goes back to the free pool
  free_list u_free_list (
    .clock         (clock),
    .reset         (reset),
    .alloc         (rename),
    .release_valid (retire_valid),
    .release_tag   (retire_t_old),
    .recover       (recover.blk),
    .head_tag      (head_tag)
  );

  map_table u_map_table (
    .clock     (clock),
    .reset     (reset),
    .rename    (rename),
    .dest_areg (dest_areg),
    .t_new     (head_tag),
    .recover   (recover.blk),
    .t_old     (map_t_old)
  );

endmodule

`default_nettype wire

// ==== design/reorder_buffer.sv ====
//**********************************************************
// circular reorder buffer
// allocate at tail, retire at head, flush on mispredict
//**********************************************************

`default_nettype none
`timescale 1ns/100ps

module reorder_buffer
  import rename_pkg::*;
#(
  parameter int  rob_depth = 8,
  localparam int idx_w     = $clog2(rob_depth)
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             dispatch,
  input  logic             dest_valid,
  input  preg_t            t_new,
  input  preg_t            t_old_in,
  input  logic             retire,
  recover_if.blk           recover,
  output logic             dispatch_accept,
  output logic             stall,
  output logic [idx_w-1:0] rob_idx,
  output logic [idx_w-1:0] head_idx,
  output logic             retire_valid,
  output preg_t            retire_t,
  output preg_t            retire_t_old
);

  rob_entry_t           entries [rob_depth];
  logic [idx_w-1:0]     head;
  logic [idx_w-1:0]     tail;
  logic                 retire_accept;
  logic [rob_depth-1:0] flush_mask;
  rob_entry_t           new_entry;

  // retire only a valid head
  assign retire_accept = retire && entries[head].valid;

  // tail slot is free, or the full buffer frees its head this cycle
  assign dispatch_accept = dispatch && !recover.mispredict &&
                           (!entries[tail].valid || retire_accept);
  assign stall = entries[tail].valid && !retire_accept;

  // instructions without a destination carry zero tags
  always_comb begin
    new_entry.valid = 1'b1;
    new_entry.t     = dest_valid ? t_new : '0;
    new_entry.t_old = dest_valid ? t_old_in : '0;
  end

  // entries younger than the branch, up to but not including tail
  always_comb begin
    int br;
    int tl;
    br = int'(recover.branch_idx);
    tl = int'(tail);
    for (int i = 0; i < rob_depth; i++) begin
      if (br >= tl) begin
        // younger entries wrap past the end of the array
        flush_mask[i] = (i < tl) || (i > br);
      end else begin
        flush_mask[i] = (i > br) && (i < tl);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < rob_depth; i++) begin
        entries[i].valid <= 1'b0;
      end
    end else begin
      if (retire_accept) begin
        entries[head].valid <= 1'b0;
        head <= head + 1'b1;
      end
      // when full, head and tail share a slot and the write wins
      if (dispatch_accept) begin
        entries[tail] <= new_entry;
        tail <= tail + 1'b1;
      end
      if (recover.mispredict) begin
        for (int i = 0; i < rob_depth; i++) begin
          if (flush_mask[i]) begin
            entries[i].valid <= 1'b0;
          end
        end
        tail <= recover.branch_idx + 1'b1;
      end
    end
  end

  assign rob_idx      = tail;
  assign head_idx     = head;
  assign retire_valid = retire_accept;
  assign retire_t     = entries[head].t;
  assign retire_t_old = entries[head].t_old;

  // branch being recovered must still be in flight
  a_mispredict_valid : assert property (
    @(posedge clock) disable iff (reset)
    recover.mispredict |-> entries[recover.branch_idx].valid
  );

  // retire strobe only when something has been dispatched
  a_retire_valid_head : assert property (
    @(posedge clock) disable iff (reset)
    retire |-> entries[head].valid
  );

endmodule

`default_nettype wire

// ==== tb/rename_tasks.svh ====
//**********************************************************
// LFSR, value check and the five directed tests
//**********************************************************

`ifndef rename_tasks_svh
`define rename_tasks_svh

  // galois LFSR, one step per bit taken
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[6:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
    end
    return bits;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      $display("test %0d %s: %0d checks failed", test_count, name, error_count - errors_before);
    end
    errors_before = error_count;
  endtask

  task automatic test_reset_state();
    run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0, '0);
    check_value("stall", 32'(seen_stall), 32'd0);
    // first tag above the identity map
    run_cycle(1'b1, 1'b1, 5'd5, 1'b0, 1'b0, 1'b0, '0);
    check_value("dispatch_t", 32'(seen_t), 32'd32);
    check_value("dispatch_t_old", 32'(seen_t_old), 32'd5);
    check_value("dispatch_rob_idx", 32'(seen_idx), 32'd0);
    run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b1, 1'b0, '0);
    end_test("reset state");
  endtask

  task automatic test_random_rename();
    areg_t areg;
    logic dv;
    for (int n = 0; n < 20; n++) begin
      areg = areg_t'(take_bits(5));
      // about one in four has no destination
      dv = (take_bits(2) != 8'd0);
      run_cycle(1'b1, dv, areg, 1'b0, 1'b0, 1'b0, '0);
      run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b1, 1'b0, '0);
    end
    end_test("random rename");
  endtask

  task automatic test_rob_full();
    logic [idx_w-1:0] idx_before;
    for (int n = 0; n < rob_depth; n++) begin
      run_cycle(1'b1, 1'b1, areg_t'(take_bits(5)), 1'b0, 1'b0, 1'b0, '0);
    end
    run_cycle(1'b1, 1'b1, 5'd3, 1'b0, 1'b0, 1'b0, '0);
    check_value("stall", 32'(seen_stall), 32'd1);
    idx_before = seen_idx;
    // retire frees the head slot for this dispatch
    run_cycle(1'b1, 1'b1, 5'd3, 1'b0, 1'b1, 1'b0, '0);
    check_value("dispatch_rob_idx", 32'(seen_idx), 32'(idx_before));
    while (rob_q.size() != 0) begin
      run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b1, 1'b0, '0);
    end
    end_test("rob full");
  endtask

  task automatic test_retire_order();
    // four in flight, so released tags cycle back through the free list
    for (int n = 0; n < 40; n++) begin
      run_cycle(1'b1, 1'b1, areg_t'(take_bits(5)), 1'b0, rob_q.size() >= 4, 1'b0, '0);
    end
    while (rob_q.size() != 0) begin
      run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b1, 1'b0, '0);
    end
    end_test("retire order");
  endtask

  task automatic test_branch_recovery();
    logic [idx_w-1:0] br_idx;
    logic [idx_w-1:0] exp_idx;
    preg_t next_tag;
    preg_t t7;
    int drained;
    run_cycle(1'b1, 1'b1, 5'd7, 1'b0, 1'b0, 1'b0, '0);
    t7 = seen_t;
    run_cycle(1'b1, 1'b0, '0, 1'b1, 1'b0, 1'b0, '0);
    br_idx   = seen_idx;
    next_tag = free_q[0];
    run_cycle(1'b1, 1'b1, 5'd7, 1'b0, 1'b0, 1'b0, '0);
    run_cycle(1'b1, 1'b1, 5'd9, 1'b0, 1'b0, 1'b0, '0);
    run_cycle(1'b1, 1'b1, 5'd7, 1'b0, 1'b0, 1'b0, '0);
    // older instruction retires, the dispatch is dropped
    run_cycle(1'b1, 1'b1, 5'd7, 1'b0, 1'b1, 1'b1, br_idx);
    run_cycle(1'b1, 1'b1, 5'd7, 1'b0, 1'b0, 1'b0, '0);
    exp_idx = br_idx + 1'b1;
    check_value("dispatch_rob_idx", 32'(seen_idx), 32'(exp_idx));
    check_value("dispatch_t", 32'(seen_t), 32'(next_tag));
    check_value("dispatch_t_old", 32'(seen_t_old), 32'(t7));
    drained = 0;
    while (rob_q.size() != 0) begin
      run_cycle(1'b0, 1'b0, '0, 1'b0, 1'b1, 1'b0, '0);
      if (seen_retire) begin
        drained++;
      end
    end
    // the branch and the one new entry
    check_value("retire count", drained, 32'd2);
    end_test("branch recovery");
  endtask

`endif

// ==== tb/tb_rename.sv ====
//**********************************************************
// testbench top for the rename core
// clock, reset, reference model, timeout and summary
//**********************************************************

`default_nettype none
`timescale 1ns/100ps

module tb_rename
  import rename_pkg::*;
();

  localparam int rob_depth   = 8;
  localparam int idx_w       = $clog2(rob_depth);
  // the five tests take about 130 cycles after reset
  localparam int cycle_limit = 400;

  typedef struct packed {
    logic [idx_w-1:0] idx;
    preg_t            t;
    preg_t            t_old;
  } model_entry_t;

  logic clock, reset, dispatch, dest_valid, is_branch, retire, mispredict, resolve;
  areg_t dest_areg;
  logic [idx_w-1:0] branch_idx, dispatch_rob_idx, head_idx;
  logic stall, retire_valid;
  preg_t dispatch_t, dispatch_t_old, retire_t, retire_t_old;

  // reference model state
  model_entry_t rob_q [$];
  preg_t free_q [$];
  // tags handed out since the last branch
  preg_t alloc_since [$];
  preg_t model_map [areg_count];
  preg_t snap_map [areg_count];
  int model_head, model_tail;

  int error_count, errors_before, test_count, cycle_count;
  logic [31:0] lfsr_state;
  // outputs seen in the last driven cycle
  logic seen_stall;
  logic seen_retire;
  preg_t seen_t, seen_t_old;
  logic [idx_w-1:0] seen_idx;

  rename_top #(.rob_depth(rob_depth)) i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("run stopped after %0d cycles with tests still running", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic model_reset();
    rob_q.delete();
    free_q.delete();
    alloc_since.delete();
    for (int i = 0; i < areg_count; i++) begin
      model_map[i] = preg_t'(i);
    end
    for (int i = 0; i < free_count; i++) begin
      free_q.push_back(preg_t'(areg_count + i));
    end
    model_head = 0;
    model_tail = 0;
  endtask

  // drive one cycle, check against the model, then step the model
  task automatic run_cycle(input logic disp, input logic dv, input areg_t areg,
                           input logic br, input logic ret, input logic mp,
                           input logic [idx_w-1:0] bidx);
    model_entry_t e;
    logic full;
    logic ret_ok;
    logic accept;
    preg_t exp_t;
    preg_t exp_t_old;
    dispatch   = disp;
    dest_valid = dv;
    dest_areg  = areg;
    is_branch  = br;
    retire     = ret;
    mispredict = mp;
    branch_idx = bidx;
    full      = (rob_q.size() == rob_depth);
    ret_ok    = ret && (rob_q.size() != 0);
    accept    = disp && !mp && (!full || ret_ok);
    exp_t     = dv ? free_q[0] : '0;
    exp_t_old = dv ? model_map[areg] : '0;
    #2;
    seen_stall  = stall;
    seen_retire = retire_valid;
    seen_t      = dispatch_t;
    seen_t_old  = dispatch_t_old;
    seen_idx    = dispatch_rob_idx;
    check_value("stall", 32'(stall), 32'(full && !ret_ok));
    check_value("dispatch_rob_idx", 32'(dispatch_rob_idx), model_tail);
    check_value("head_idx", 32'(head_idx), model_head);
    check_value("retire_valid", 32'(retire_valid), 32'(ret_ok));
    if (disp) begin
      check_value("dispatch_t", 32'(dispatch_t), 32'(exp_t));
      check_value("dispatch_t_old", 32'(dispatch_t_old), 32'(exp_t_old));
    end
    if (ret_ok) begin
      check_value("retire_t", 32'(retire_t), 32'(rob_q[0].t));
      check_value("retire_t_old", 32'(retire_t_old), 32'(rob_q[0].t_old));
    end
    @(posedge clock);
    #1;
    dispatch   = 1'b0;
    is_branch  = 1'b0;
    retire     = 1'b0;
    mispredict = 1'b0;
    if (ret_ok) begin
      e = rob_q.pop_front();
      if (e.t_old != '0) begin
        free_q.push_back(e.t_old);
      end
      model_head = (model_head + 1) % rob_depth;
    end
    if (accept) begin
      if (dv) begin
        void'(free_q.pop_front());
        model_map[areg] = exp_t;
        alloc_since.push_back(exp_t);
      end
      e.idx   = idx_w'(model_tail);
      e.t     = exp_t;
      e.t_old = exp_t_old;
      rob_q.push_back(e);
      model_tail = (model_tail + 1) % rob_depth;
      // checkpoint includes the branch's own rename
      if (br) begin
        snap_map = model_map;
        alloc_since.delete();
      end
    end
    if (mp) begin
      model_map = snap_map;
      while (alloc_since.size() != 0) begin
        free_q.push_front(alloc_since.pop_back());
      end
      while (rob_q[$].idx != bidx) begin
        void'(rob_q.pop_back());
      end
      model_tail = (int'(bidx) + 1) % rob_depth;
    end
  endtask

  initial begin
    cycle_count   = 0;
    error_count   = 0;
    errors_before = 0;
    test_count    = 0;
    lfsr_state    = 32'h8e87;
    reset         = 1'b1;
    dispatch      = 1'b0;
    dest_valid    = 1'b0;
    dest_areg     = '0;
    is_branch     = 1'b0;
    retire        = 1'b0;
    mispredict    = 1'b0;
    branch_idx    = '0;
    resolve       = 1'b0;
    model_reset();
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
    test_reset_state();
    test_random_rename();
    test_rob_full();
    test_retire_order();
    test_branch_recovery();
    $display("tests run: %0d, checks failed: %0d", test_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  `include "rename_tasks.svh"

endmodule

`default_nettype wire
